/* Bender.yml */
package:
  name: mips_core

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - dec_op_if.sv
  - instr_queue.sv
  - main_control.sv
  - reg_bank.sv
  - decode_stage.sv
  - execute_stage.sv
  - mips_core.sv
  - target: simulation
    files:
      - wb_checker.sv
      - tb_mips_core.sv

/* all.f */
+incdir+.
mips_pkg.sv
dec_op_if.sv
instr_queue.sv
main_control.sv
reg_bank.sv
decode_stage.sv
execute_stage.sv
mips_core.sv
wb_checker.sv
tb_mips_core.sv

/* dec_op_if.sv */
/*
 * one decoded operation from decode to execute
 * valid/ready transfer, payload held while valid waits for ready
 */
`timescale 1ns/1ps

interface dec_op_if;
	import mips_pkg::*;

	// handshake
	logic valid;
	logic ready;

	// payload
	alu_sel_t alu_sel;
	word_t op_a;
	word_t op_b;
	// destination, 0 means the result is discarded by the bank
	reg_addr_t rd;

	// decode side
	modport src (
		output valid,
		output alu_sel,
		output op_a,
		output op_b,
		output rd,
		input ready
	);

	// execute side
	modport dst (
		input valid,
		input alu_sel,
		input op_a,
		input op_b,
		input rd,
		output ready
	);

endinterface

/* decode_stage.sv */
/*
 * takes one queue entry per cycle unless blocked by its own registered op
 * forwarding covers only the result held in execute
 */
`timescale 1ns/1ps

module decode_stage (
	input logic i_clk,
	input logic i_nrst,
	// queue head
	input logic i_q_valid,
	input mips_pkg::word_t i_q_instr,
	output logic o_q_ready,
	// pending result in execute
	input logic i_fwd_valid,
	input mips_pkg::reg_addr_t i_fwd_rd,
	input mips_pkg::word_t i_fwd_data,
	// bank write from execute
	input logic i_we,
	input mips_pkg::reg_addr_t i_wa,
	input mips_pkg::word_t i_wd,
	// decoded operation out
	dec_op_if.src o_dec
);
	import mips_pkg::*;

	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t dst;
	word_t rs_bank;
	word_t rt_bank;
	word_t rs_val;
	word_t rt_val;
	word_t imm_ext;
	alu_sel_t alu_sel;
	logic use_imm;
	logic zero_ext;
	logic dst_rt;
	logic supported;
	logic rt_used;
	logic hazard;
	logic take;

	// ====================
	// fields and operands
	// ====================
	assign rs = i_q_instr[25:21];
	assign rt = i_q_instr[20:16];
	assign rd = i_q_instr[15:11];

	reg_bank u_reg_bank (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_rs(rs),
		.i_rt(rt),
		.i_we(i_we),
		.i_wa(i_wa),
		.i_wd(i_wd),
		.o_rs_data(rs_bank),
		.o_rt_data(rt_bank)
	);

	main_control u_main_control (
		.i_opcode(i_q_instr[31:26]),
		.i_funct(i_q_instr[5:0]),
		.o_alu_sel(alu_sel),
		.o_use_imm(use_imm),
		.o_zero_ext(zero_ext),
		.o_dst_rt(dst_rt),
		.o_supported(supported)
	);

	// newest value wins, execute result over bank
	assign rs_val = (i_fwd_valid && (i_fwd_rd != '0) && (i_fwd_rd == rs)) ? i_fwd_data : rs_bank;
	assign rt_val = (i_fwd_valid && (i_fwd_rd != '0) && (i_fwd_rd == rt)) ? i_fwd_data : rt_bank;

	// andi and ori zero extend, the rest sign extend
	assign imm_ext = zero_ext ? {16'h0000, i_q_instr[15:0]} :
		{{16{i_q_instr[15]}}, i_q_instr[15:0]};
	assign dst = dst_rt ? rt : rd;

	// ====================
	// interlock
	// ====================
	// rt is a source only for r-type
	assign rt_used = supported && !use_imm;
	// registered op not yet in execute, its result cannot be forwarded
	assign hazard = o_dec.valid && (o_dec.rd != '0) && supported &&
		((o_dec.rd == rs) || (rt_used && (o_dec.rd == rt)));

	// register free or draining this cycle
	assign o_q_ready = (!o_dec.valid || o_dec.ready) && !hazard;
	assign take = i_q_valid && o_q_ready;

	// ====================
	// decode register
	// ====================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_dec.valid <= 1'b0;
		end else if (take) begin
			o_dec.valid <= 1'b1;
		end else if (o_dec.ready) begin
			o_dec.valid <= 1'b0;
		end
	end

	// payload, unsupported becomes 0 + 0 into r0
	always_ff @(posedge i_clk) begin
		if (take) begin
			o_dec.alu_sel <= alu_sel;
			o_dec.op_a <= supported ? rs_val : '0;
			o_dec.op_b <= !supported ? '0 : (use_imm ? imm_ext : rt_val);
			o_dec.rd <= supported ? dst : '0;
		end
	end

endmodule

/* execute_stage.sv */
/*
 * single result register, also the forwarding source for decode
 * the bank write fires only when the write-back beat completes
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module execute_stage (
	input logic i_clk,
	input logic i_nrst,
	input logic i_wb_ready,
	// decoded operation in
	dec_op_if.dst i_dec,
	// write-back beat
	output logic o_wb_valid,
	output mips_pkg::reg_addr_t o_wb_rd,
	output mips_pkg::word_t o_wb_data,
	// register bank write
	output logic o_we,
	output mips_pkg::reg_addr_t o_wa,
	output mips_pkg::word_t o_wd
);
	import mips_pkg::*;

	word_t alu_res;
	logic wb_done;
	logic take;

	// ====================
	// alu
	// ====================
	always_comb begin
		case (i_dec.alu_sel)
			`ALU_ADD: alu_res = i_dec.op_a + i_dec.op_b;
			`ALU_SUB: alu_res = i_dec.op_a - i_dec.op_b;
			`ALU_AND: alu_res = i_dec.op_a & i_dec.op_b;
			`ALU_OR: alu_res = i_dec.op_a | i_dec.op_b;
			// signed compare
			`ALU_SLT: alu_res = {31'd0, $signed(i_dec.op_a) < $signed(i_dec.op_b)};
			// immediate into the upper half
			`ALU_LUI: alu_res = {i_dec.op_b[15:0], 16'h0000};
			default: alu_res = '0;
		endcase
	end

	// ====================
	// handshakes
	// ====================
	assign wb_done = o_wb_valid && i_wb_ready;
	// empty, or emptied by this cycle's beat
	assign i_dec.ready = !o_wb_valid || i_wb_ready;
	assign take = i_dec.valid && i_dec.ready;

	// ====================
	// result register
	// ====================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_wb_valid <= 1'b0;
		end else if (take) begin
			o_wb_valid <= 1'b1;
		end else if (wb_done) begin
			o_wb_valid <= 1'b0;
		end
	end

	// held while i_wb_ready is low
	always_ff @(posedge i_clk) begin
		if (take) begin
			o_wb_rd <= i_dec.rd;
			o_wb_data <= alu_res;
		end
	end

	// bank write on the completing beat
	assign o_we = wb_done;
	assign o_wa = o_wb_rd;
	assign o_wd = o_wb_data;

endmodule

/* instr_queue.sv */
/*
 * circular instruction buffer, DEPTH must be a power of two
 * write and read may both happen in one cycle
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module instr_queue #(
	parameter int DEPTH = `QUEUE_DEPTH
) (
	input logic i_clk,
	input logic i_nrst,
	// upstream side
	input logic i_valid,
	input mips_pkg::word_t i_instr,
	output logic o_ready,
	// downstream side
	output logic o_valid,
	output mips_pkg::word_t o_instr,
	input logic i_ready
);
	import mips_pkg::*;

	// address bits, pointers carry one extra wrap bit
	localparam int AW = $clog2(DEPTH);

	word_t mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic empty;
	logic full;
	logic push;
	logic pop;

	// same wrap bit means empty, different wrap bit means full
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign o_ready = !full;
	assign o_valid = !empty;
	assign o_instr = mem[rd_ptr[AW-1:0]];

	assign push = i_valid && o_ready;
	assign pop = o_valid && i_ready;

	// ====================
	// pointers
	// ====================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// storage, no reset needed
	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= i_instr;
		end
	end

endmodule

/* main_control.sv */
/*
 * opcode and funct decoder for the supported subset only
 * anything else is flagged unsupported and decodes as an add
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module main_control (
	input mips_pkg::opcode_t i_opcode,
	input mips_pkg::funct_t i_funct,
	output mips_pkg::alu_sel_t o_alu_sel,
	output logic o_use_imm,
	output logic o_zero_ext,
	output logic o_dst_rt,
	output logic o_supported
);
	import mips_pkg::*;

	// opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_ANDI = 6'h0c;
	localparam opcode_t OP_ORI = 6'h0d;
	localparam opcode_t OP_LUI = 6'h0f;

	// r-type function codes
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	always_comb begin
		// defaults, unsupported add with rd as destination
		o_alu_sel = `ALU_ADD;
		o_use_imm = 1'b0;
		o_zero_ext = 1'b0;
		o_dst_rt = 1'b0;
		o_supported = 1'b1;
		case (i_opcode)
			OP_RTYPE: begin
				case (i_funct)
					FN_ADDU: o_alu_sel = `ALU_ADD;
					FN_SUBU: o_alu_sel = `ALU_SUB;
					FN_AND: o_alu_sel = `ALU_AND;
					FN_OR: o_alu_sel = `ALU_OR;
					FN_SLT: o_alu_sel = `ALU_SLT;
					default: o_supported = 1'b0;
				endcase
			end
			// i-type, destination is rt
			OP_ADDIU: begin
				o_use_imm = 1'b1;
				o_dst_rt = 1'b1;
			end
			OP_ANDI: begin
				o_alu_sel = `ALU_AND;
				o_use_imm = 1'b1;
				o_zero_ext = 1'b1;
				o_dst_rt = 1'b1;
			end
			OP_ORI: begin
				o_alu_sel = `ALU_OR;
				o_use_imm = 1'b1;
				o_zero_ext = 1'b1;
				o_dst_rt = 1'b1;
			end
			// upper immediate, execute shifts it up
			OP_LUI: begin
				o_alu_sel = `ALU_LUI;
				o_use_imm = 1'b1;
				o_dst_rt = 1'b1;
			end
			default: o_supported = 1'b0;
		endcase
	end

endmodule

/* mips_core.sv */
/*
 * mips32 subset core: queue, decode, execute
 * one write-back beat per accepted instruction, in order
 */
`timescale 1ns/1ps

module mips_core (
	input logic i_clk,
	input logic i_nrst,
	// instruction input
	input logic i_instr_valid,
	output logic o_instr_ready,
	input mips_pkg::word_t i_instr,
	// write-back output
	output logic o_wb_valid,
	input logic i_wb_ready,
	output mips_pkg::reg_addr_t o_wb_rd,
	output mips_pkg::word_t o_wb_data
);
	import mips_pkg::*;

	// queue to decode
	logic q_valid;
	logic q_ready;
	word_t q_instr;

	// bank write from execute
	logic we;
	reg_addr_t wa;
	word_t wd;

	// decode to execute
	dec_op_if u_dec_op ();

	instr_queue u_instr_queue (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_valid(i_instr_valid),
		.i_instr(i_instr),
		.o_ready(o_instr_ready),
		.o_valid(q_valid),
		.o_instr(q_instr),
		.i_ready(q_ready)
	);

	// forwarding taps the write-back outputs directly
	decode_stage u_decode_stage (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_q_valid(q_valid),
		.i_q_instr(q_instr),
		.o_q_ready(q_ready),
		.i_fwd_valid(o_wb_valid),
		.i_fwd_rd(o_wb_rd),
		.i_fwd_data(o_wb_data),
		.i_we(we),
		.i_wa(wa),
		.i_wd(wd),
		.o_dec(u_dec_op.src)
	);

	execute_stage u_execute_stage (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_wb_ready(i_wb_ready),
		.i_dec(u_dec_op.dst),
		.o_wb_valid(o_wb_valid),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data),
		.o_we(we),
		.o_wa(wa),
		.o_wd(wd)
	);

endmodule

/* mips_params.svh */
/*
 * queue depth must be a power of two
 * alu selector codes are 3 bits wide to match alu_sel_t
 */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ====================
// instruction queue
// ====================
`define QUEUE_DEPTH 4

// ====================
// alu selector codes
// ====================
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_SLT 3'd4
`define ALU_LUI 3'd5

`endif

/* mips_pkg.sv */
/*
 * shared vector types for the mips32 subset core
 * widths follow the mips32 instruction encoding
 */
package mips_pkg;

	// ====================
	// data path
	// ====================
	// data and instruction words
	typedef logic [31:0] word_t;

	// register number, 32 registers
	typedef logic [4:0] reg_addr_t;

	// ====================
	// instruction fields
	// ====================
	// opcode in bits 31:26
	typedef logic [5:0] opcode_t;

	// function code in bits 5:0, r-type only
	typedef logic [5:0] funct_t;

	// ====================
	// execute control
	// ====================
	// alu operation, codes live in mips_params.svh
	typedef logic [2:0] alu_sel_t;

endpackage

/* mips_stimulus.txt */
// columns: instruction word, expected write-back rd, expected write-back data (all hex)
// one instruction per line, beats are expected in this order
2401fffb 01 fffffffb
24020064 02 00000064
3023ff0f 03 0000ff0b
34048001 04 00008001
3c058765 05 87650000
24268000 06 ffff7ffb
00223821 07 0000005f
00414023 08 00000069
00644824 09 00008001
00a45025 0a 87658001
0022582a 0b 00000001
0041602a 0c 00000000
00a6682a 0d 00000001
240e0007 0e 00000007
01ce7821 0f 0000000e
01ee8023 10 00000007
020f8825 11 0000000f
25ce0001 0e 00000008
01d19021 12 00000017
24001234 00 00001234
00029821 13 00000064
0000a025 14 00000000
8c410000 00 00000000
00011880 00 00000000
0023a821 15 0000ff06
30d6ffff 16 00007ffb
000db823 17 ffffffff
02e0c02a 18 00000001

/* reg_bank.sv */
/*
 * 32 x 32 register file, two combinational reads, one write
 * register 0 reads as zero; no bypass from a write in the same cycle
 */
`timescale 1ns/1ps

module reg_bank (
	input logic i_clk,
	input logic i_nrst,
	// read ports
	input mips_pkg::reg_addr_t i_rs,
	input mips_pkg::reg_addr_t i_rt,
	// write port
	input logic i_we,
	input mips_pkg::reg_addr_t i_wa,
	input mips_pkg::word_t i_wd,
	output mips_pkg::word_t o_rs_data,
	output mips_pkg::word_t o_rt_data
);
	import mips_pkg::*;

	word_t regs [32];

	// ====================
	// write
	// ====================
	// whole bank starts at zero, writes to r0 dropped
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_wa != '0)) begin
			regs[i_wa] <= i_wd;
		end
	end

	// ====================
	// read
	// ====================
	assign o_rs_data = (i_rs == '0) ? '0 : regs[i_rs];
	assign o_rt_data = (i_rt == '0) ? '0 : regs[i_rt];

endmodule

/* tb_mips_core.sv */
/*
 * reads up to MAX_INSTR instructions from mips_stimulus.txt
 * write-back is held off at the start so the queue fills
 */
`timescale 1ns/1ps

module tb_mips_core;
	import mips_pkg::*;

	localparam int MAX_INSTR = 64;
	// wb_ready low this long after reset
	localparam int WB_HOLD_CYCLES = 24;

	logic i_clk;
	logic i_nrst;
	logic i_instr_valid;
	logic o_instr_ready;
	word_t i_instr;
	logic o_wb_valid;
	logic i_wb_ready;
	reg_addr_t o_wb_rd;
	word_t o_wb_data;

	// raw file contents with three words per instruction
	word_t stim [3*MAX_INSTR];
	word_t instr_mem [MAX_INSTR];
	reg_addr_t exp_rd [MAX_INSTR];
	word_t exp_data [MAX_INSTR];
	int n_instr = 0;
	int timeout_limit = 0;
	int cycle_count = 0;
	int setup_errors = 0;
	int beat_count;
	int error_count;
	logic run_end;
	reg_addr_t cur_exp_rd;
	word_t cur_exp_data;
	logic [31:0] rnd;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	mips_core i_mips_core (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_instr_valid(i_instr_valid),
		.o_instr_ready(o_instr_ready),
		.i_instr(i_instr),
		.o_wb_valid(o_wb_valid),
		.i_wb_ready(i_wb_ready),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data)
	);

	// expected values for the checker's next beat
	assign cur_exp_rd = (beat_count < n_instr) ? exp_rd[beat_count] : '0;
	assign cur_exp_data = (beat_count < n_instr) ? exp_data[beat_count] : '0;

	wb_checker u_wb_checker (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_instr_valid(i_instr_valid),
		.i_instr_ready(o_instr_ready),
		.i_wb_valid(o_wb_valid),
		.i_wb_ready(i_wb_ready),
		.i_wb_rd(o_wb_rd),
		.i_wb_data(o_wb_data),
		.i_exp_total(n_instr),
		.i_exp_rd(cur_exp_rd),
		.i_exp_data(cur_exp_data),
		.i_end(run_end),
		.o_beat_count(beat_count),
		.o_error_count(error_count)
	);

	// ====================
	// clock and watchdog
	// ====================
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	initial begin : watchdog
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit) begin
			@(posedge i_clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout after %0d cycles, the DUT stopped producing write-back beats",
			cycle_count);
		// checker reports the missing beats at run end
		run_end <= 1'b1;
		repeat (2) @(posedge i_clk);
		$display("beats %0d of %0d, errors %0d", beat_count, n_instr,
			error_count + setup_errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ====================
	// stimulus
	// ====================
	initial begin : drive
		int idx;
		int since_reset;
		int total_errors;
		i_nrst = 1'b0;
		i_instr_valid = 1'b0;
		i_instr = '0;
		i_wb_ready = 1'b0;
		run_end = 1'b0;
		rnd = 32'h7520;
		$readmemh("mips_stimulus.txt", stim);
		while ((n_instr < MAX_INSTR) && !$isunknown(stim[3*n_instr])) begin
			instr_mem[n_instr] = stim[3*n_instr];
			exp_rd[n_instr] = stim[3*n_instr+1][4:0];
			exp_data[n_instr] = stim[3*n_instr+2];
			n_instr = n_instr + 1;
		end
		if (n_instr == 0) begin
			$display("no instructions read from mips_stimulus.txt");
			setup_errors = 1;
		end
		timeout_limit = n_instr * 20 + 100;
		repeat (4) @(posedge i_clk);
		i_nrst <= 1'b1;
		idx = 0;
		since_reset = 0;
		while (beat_count < n_instr) begin
			@(posedge i_clk);
			if (i_instr_valid && o_instr_ready) begin
				idx = idx + 1;
			end
			// hold the word while valid waits for ready
			if (!(i_instr_valid && !o_instr_ready)) begin
				rnd = xorshift(rnd);
				if ((idx < n_instr) && (rnd[1:0] != 2'b00)) begin
					i_instr_valid <= 1'b1;
					i_instr <= instr_mem[idx];
				end else begin
					i_instr_valid <= 1'b0;
				end
			end
			// write-back stalls about one cycle in three
			rnd = xorshift(rnd);
			if (since_reset < WB_HOLD_CYCLES) begin
				i_wb_ready <= 1'b0;
			end else begin
				i_wb_ready <= ((rnd % 3) != 0);
			end
			since_reset = since_reset + 1;
		end
		// drain and then look for surplus beats
		@(posedge i_clk);
		i_instr_valid <= 1'b0;
		i_wb_ready <= 1'b1;
		repeat (10) @(posedge i_clk);
		run_end <= 1'b1;
		repeat (2) @(posedge i_clk);
		total_errors = error_count + setup_errors;
		$display("beats %0d of %0d, errors %0d", beat_count, n_instr, total_errors);
		if (total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* wb_checker.sv */
/*
 * compares write-back beats in order with the expected rd and data
 * expected values arrive per beat and are indexed by o_beat_count
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module wb_checker (
	input logic i_clk,
	input logic i_nrst,
	// instruction port for occupancy tracking
	input logic i_instr_valid,
	input logic i_instr_ready,
	// write-back port
	input logic i_wb_valid,
	input logic i_wb_ready,
	input mips_pkg::reg_addr_t i_wb_rd,
	input mips_pkg::word_t i_wb_data,
	// expected values for the next beat
	input int i_exp_total,
	input mips_pkg::reg_addr_t i_exp_rd,
	input mips_pkg::word_t i_exp_data,
	input logic i_end,
	output int o_beat_count,
	output int o_error_count
);
	import mips_pkg::*;

	// accepted but not yet written back
	int in_flight;
	int full_cycles;
	logic end_seen;

	always @(posedge i_clk, negedge i_nrst) begin : check
		int errs;
		int flight;
		if (!i_nrst) begin
			o_beat_count <= 0;
			o_error_count <= 0;
			in_flight <= 0;
			full_cycles <= 0;
			end_seen <= 1'b0;
		end else begin
			errs = 0;
			flight = in_flight;
			if (i_instr_valid && i_instr_ready) begin
				flight = flight + 1;
			end
			// ====================
			// queue full flag
			// ====================
			// queue, decode and execute hold at most depth + 2
			if (!i_instr_ready) begin
				full_cycles <= full_cycles + 1;
				if (in_flight < `QUEUE_DEPTH) begin
					$display("Error at %0t ns: o_instr_ready expected 1, got 0 (%0d in flight)",
						$time, in_flight);
					errs = errs + 1;
				end
			end else if (in_flight >= `QUEUE_DEPTH + 2) begin
				$display("Error at %0t ns: o_instr_ready expected 0, got 1 (%0d in flight)",
					$time, in_flight);
				errs = errs + 1;
			end
			// ====================
			// write-back beats
			// ====================
			if (i_wb_valid && i_wb_ready) begin
				flight = flight - 1;
				if (o_beat_count >= i_exp_total) begin
					$display("surplus write-back beat at %0t: rd %0d data %h after all %0d beats",
						$time, i_wb_rd, i_wb_data, i_exp_total);
					errs = errs + 1;
				end else begin
					if (i_wb_rd !== i_exp_rd) begin
						$display("Error at %0t ns: o_wb_rd expected %0d, got %0d (beat %0d)",
							$time, i_exp_rd, i_wb_rd, o_beat_count);
						errs = errs + 1;
					end
					if (i_wb_data !== i_exp_data) begin
						$display("Error at %0t ns: o_wb_data expected %h, got %h (beat %0d)",
							$time, i_exp_data, i_wb_data, o_beat_count);
						errs = errs + 1;
					end
				end
				o_beat_count <= o_beat_count + 1;
			end
			// end of run checks run once
			if (i_end && !end_seen) begin
				end_seen <= 1'b1;
				if (o_beat_count < i_exp_total) begin
					$display("missing write-back beats: expected %0d, saw %0d",
						i_exp_total, o_beat_count);
					errs = errs + 1;
				end
				if (full_cycles == 0) begin
					$display("o_instr_ready never fell, the queue never filled");
					errs = errs + 1;
				end
			end
			in_flight <= flight;
			o_error_count <= o_error_count + errs;
		end
	end

endmodule
